/* source/lz_pkg.sv */
`default_nettype none

package lz_pkg;

    localparam int JOB_LEN              = 256;
    localparam int JOB_LEN_LOG2         = 8;
    localparam int LAZY_LEN             = 4;
    localparam int LAZY_LOG2            = 2;
    localparam int MATCH_LEN_WIDTH      = 10;
    localparam int SEQ_OFFSET_BITS      = 16;
    localparam int SEQ_OFFSET_BITS_LOG2 = 5;
    localparam int GAIN_BITS            = 12;  // signed, 4*len plus bonus
    localparam int SEQ_LL_BITS          = 10;
    localparam int SEQ_ML_BITS          = 10;
    localparam int PIPE_LATENCY         = 2 + LAZY_LOG2 + 1;
    localparam int SEQ_QUEUE_DEPTH      = 4;  // power of two

    typedef struct packed {
        logic [SEQ_LL_BITS-1:0]     ll;
        logic [SEQ_ML_BITS-1:0]     ml;
        logic [SEQ_OFFSET_BITS-1:0] offset;
        logic                       delim;
        logic                       eoj;
        logic [SEQ_ML_BITS-1:0]     overlap_len;  // bytes spilling into next job
    } seq_t;

endpackage

`default_nettype wire

/* source/priority_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module priority_encoder #(
    parameter int WIDTH = 16
) (
    input  logic [WIDTH-1:0]         i_vec,
    output logic                     o_valid,
    output logic [$clog2(WIDTH)-1:0] o_index
);

    always_comb begin
        o_valid = |i_vec;
        o_index = '0;
        // scan downwards so the lowest set bit is written last
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (i_vec[i]) begin
                o_index = $clog2(WIDTH)'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* source/lazy_summary_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module lazy_summary_pipeline import lz_pkg::*; (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic                                i_match_done,
    input  logic [JOB_LEN_LOG2-1:0]             i_match_head_ptr,
    input  logic [JOB_LEN_LOG2-1:0]             i_seq_head_ptr,
    input  logic                                i_delim,
    input  logic [LAZY_LEN-1:0]                 i_match_valid,
    input  logic [LAZY_LEN*MATCH_LEN_WIDTH-1:0] i_match_len,
    input  logic [LAZY_LEN*SEQ_OFFSET_BITS-1:0] i_offset,
    output logic                                o_summary_done,
    output logic [JOB_LEN_LOG2-1:0]             o_seq_head_ptr,
    output logic [SEQ_LL_BITS-1:0]              o_summary_ll,
    output logic [SEQ_ML_BITS-1:0]              o_summary_ml,
    output logic [SEQ_OFFSET_BITS-1:0]          o_summary_offset,
    output logic                                o_summary_delim,
    output logic                                o_summary_eoj,
    output logic [SEQ_ML_BITS-1:0]              o_summary_overlap_len,
    output logic                                o_move_to_next_job,
    output logic [MATCH_LEN_WIDTH-1:0]          o_move_forward
);

    logic [SEQ_OFFSET_BITS-1:0]         rev_off  [LAZY_LEN];
    logic                               enc_valid[LAZY_LEN];
    logic [$clog2(SEQ_OFFSET_BITS)-1:0] enc_idx  [LAZY_LEN];
    logic [SEQ_OFFSET_BITS_LOG2-1:0]    off_bits [LAZY_LEN];

    for (genvar g = 0; g < LAZY_LEN; g++) begin : g_bits
        assign rev_off[g] = {<<{i_offset[g*SEQ_OFFSET_BITS +: SEQ_OFFSET_BITS]}};

        priority_encoder #(.WIDTH(SEQ_OFFSET_BITS)) u_enc (
            .i_vec   (rev_off[g]),
            .o_valid (enc_valid[g]),
            .o_index (enc_idx[g])
        );

        // lowest bit of reversed offset gives msb position
        assign off_bits[g] = enc_valid[g] ?
            SEQ_OFFSET_BITS_LOG2'(SEQ_OFFSET_BITS - int'(enc_idx[g])) : '0;
    end

    logic [PIPE_LATENCY-1:0] done_sr;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            done_sr <= '0;
        end else begin
            done_sr <= {done_sr[PIPE_LATENCY-2:0], i_match_done};
        end
    end

    assign o_summary_done = done_sr[PIPE_LATENCY-1];

    logic [JOB_LEN_LOG2-1:0]         s0_head;
    logic                            s0_delim;
    logic [LAZY_LEN-1:0]             s0_valid;
    logic [JOB_LEN_LOG2:0]           s0_ll   [LAZY_LEN];
    logic [MATCH_LEN_WIDTH-1:0]      s0_len  [LAZY_LEN];
    logic [SEQ_OFFSET_BITS-1:0]      s0_off  [LAZY_LEN];
    logic [SEQ_OFFSET_BITS_LOG2-1:0] s0_bits [LAZY_LEN];
    logic signed [GAIN_BITS-1:0]     s0_pgain[LAZY_LEN];

    always_ff @(posedge clk) begin
        s0_head  <= i_seq_head_ptr;
        s0_delim <= i_delim;
        s0_valid <= i_match_valid;
        for (int i = 0; i < LAZY_LEN; i++) begin
            s0_ll[i]    <= {1'b0, i_match_head_ptr} - {1'b0, i_seq_head_ptr}
                           + (JOB_LEN_LOG2+1)'(i);
            s0_len[i]   <= i_match_len[i*MATCH_LEN_WIDTH +: MATCH_LEN_WIDTH];
            s0_off[i]   <= i_offset[i*SEQ_OFFSET_BITS +: SEQ_OFFSET_BITS];
            s0_bits[i]  <= off_bits[i];
            s0_pgain[i] <= GAIN_BITS'({i_match_len[i*MATCH_LEN_WIDTH +: MATCH_LEN_WIDTH], 2'b00})
                           + GAIN_BITS'(4 * (LAZY_LEN - i));  // lazy bonus
        end
    end

    // level 0 is stage 1, level LAZY_LOG2 holds the winner at index 0
    logic [JOB_LEN_LOG2-1:0]     lv_head [LAZY_LOG2+1];
    logic                        lv_delim[LAZY_LOG2+1];
    logic [JOB_LEN_LOG2:0]       lv_ll   [LAZY_LOG2+1][LAZY_LEN];
    logic [MATCH_LEN_WIDTH-1:0]  lv_ml   [LAZY_LOG2+1][LAZY_LEN];
    logic [SEQ_OFFSET_BITS-1:0]  lv_off  [LAZY_LOG2+1][LAZY_LEN];
    logic signed [GAIN_BITS-1:0] lv_gain [LAZY_LOG2+1][LAZY_LEN];
    logic [MATCH_LEN_WIDTH-1:0]  lv_mf   [LAZY_LOG2+1][LAZY_LEN];

    always_ff @(posedge clk) begin
        lv_head[0]  <= s0_head;
        lv_delim[0] <= s0_delim;
        for (int i = 0; i < LAZY_LEN; i++) begin
            lv_ll[0][i]   <= s0_ll[i];
            lv_ml[0][i]   <= s0_len[i];
            lv_off[0][i]  <= s0_off[i];
            lv_gain[0][i] <= s0_valid[i] ? s0_pgain[i] - GAIN_BITS'(s0_bits[i])
                                         : -GAIN_BITS'(SEQ_OFFSET_BITS + 1);
            lv_mf[0][i]   <= s0_len[i] + MATCH_LEN_WIDTH'(s0_ll[i]);
        end
    end

    always_ff @(posedge clk) begin
        logic hi;
        for (int l = 0; l < LAZY_LOG2; l++) begin
            lv_head[l+1]  <= lv_head[l];
            lv_delim[l+1] <= lv_delim[l];
            for (int n = 0; n < (LAZY_LEN >> (l + 1)); n++) begin
                hi = !(lv_gain[l][2*n] > lv_gain[l][2*n+1]);  // ties go high
                lv_ll[l+1][n]   <= lv_ll[l][2*n + int'(hi)];
                lv_ml[l+1][n]   <= lv_ml[l][2*n + int'(hi)];
                lv_off[l+1][n]  <= lv_off[l][2*n + int'(hi)];
                lv_gain[l+1][n] <= lv_gain[l][2*n + int'(hi)];
                lv_mf[l+1][n]   <= lv_mf[l][2*n + int'(hi)];
            end
        end
    end

    logic [MATCH_LEN_WIDTH+1:0] ovl_sum;
    logic                       ovl_neg;

    assign ovl_sum = {2'b00, lv_mf[LAZY_LOG2][0]} + (MATCH_LEN_WIDTH+2)'(lv_head[LAZY_LOG2])
                     - (MATCH_LEN_WIDTH+2)'(JOB_LEN);
    assign ovl_neg = ovl_sum[MATCH_LEN_WIDTH+1];  // still inside this job

    always_ff @(posedge clk) begin
        o_seq_head_ptr     <= lv_head[LAZY_LOG2];
        o_summary_delim    <= lv_delim[LAZY_LOG2];
        o_summary_eoj      <= !ovl_neg;
        o_move_to_next_job <= !ovl_neg;
        o_move_forward     <= ovl_neg ? lv_mf[LAZY_LOG2][0] : '0;
        if (!ovl_neg && lv_delim[LAZY_LOG2]) begin  // flush trailing literals
            o_summary_ll          <= SEQ_LL_BITS'(JOB_LEN) - SEQ_LL_BITS'(lv_head[LAZY_LOG2]);
            o_summary_ml          <= '0;
            o_summary_offset      <= '0;
            o_summary_overlap_len <= '0;
        end else begin
            o_summary_ll          <= SEQ_LL_BITS'(lv_ll[LAZY_LOG2][0]);
            o_summary_ml          <= lv_ml[LAZY_LOG2][0];
            o_summary_offset      <= lv_off[LAZY_LOG2][0];
            o_summary_overlap_len <= ovl_neg ? '0 : ovl_sum[SEQ_ML_BITS-1:0];
        end
    end

endmodule

`default_nettype wire

/* source/seq_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_scheduler import lz_pkg::*; (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic                                i_cand_req,
    input  logic [JOB_LEN_LOG2-1:0]             i_cand_match_head,
    input  logic                                i_cand_delim,
    input  logic [LAZY_LEN-1:0]                 i_cand_valid,
    input  logic [LAZY_LEN*MATCH_LEN_WIDTH-1:0] i_cand_len,
    input  logic [LAZY_LEN*SEQ_OFFSET_BITS-1:0] i_cand_offset,
    input  logic                                i_summary_done,
    input  logic [JOB_LEN_LOG2-1:0]             i_summary_seq_head_ptr,
    input  logic [SEQ_LL_BITS-1:0]              i_summary_ll,
    input  logic [SEQ_ML_BITS-1:0]              i_summary_ml,
    input  logic [SEQ_OFFSET_BITS-1:0]          i_summary_offset,
    input  logic                                i_summary_delim,
    input  logic                                i_summary_eoj,
    input  logic [SEQ_ML_BITS-1:0]              i_summary_overlap_len,
    input  logic                                i_move_to_next_job,
    input  logic [MATCH_LEN_WIDTH-1:0]          i_move_forward,
    input  logic                                i_queue_full,
    output logic                                o_cand_ack,
    output logic                                o_match_done,
    output logic [JOB_LEN_LOG2-1:0]             o_seq_head_ptr,
    output logic [JOB_LEN_LOG2-1:0]             o_match_head_ptr,
    output logic                                o_delim,
    output logic [LAZY_LEN-1:0]                 o_match_valid,
    output logic [LAZY_LEN*MATCH_LEN_WIDTH-1:0] o_match_len,
    output logic [LAZY_LEN*SEQ_OFFSET_BITS-1:0] o_offset,
    output logic                                o_push,
    output seq_t                                o_push_seq
);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_SUM,
        ST_ACK,
        ST_REQ_LOW
    } state_t;

    state_t state;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state          <= ST_IDLE;
            o_seq_head_ptr <= '0;
        end else begin
            case (state)
                ST_IDLE:     if (i_cand_req) state <= ST_ISSUE;
                ST_ISSUE:    if (!i_queue_full) state <= ST_WAIT_SUM;  // hold off while full
                ST_WAIT_SUM: begin
                    if (i_summary_done) begin
                        state <= ST_ACK;
                        if (i_move_to_next_job) begin
                            o_seq_head_ptr <= i_summary_overlap_len[JOB_LEN_LOG2-1:0];
                        end else begin
                            o_seq_head_ptr <= i_summary_seq_head_ptr
                                              + i_move_forward[JOB_LEN_LOG2-1:0];
                        end
                    end
                end
                ST_ACK:      state <= ST_REQ_LOW;
                ST_REQ_LOW:  if (!i_cand_req) state <= ST_IDLE;
                default:     state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_cand_req) begin
            o_match_head_ptr <= i_cand_match_head;
            o_delim          <= i_cand_delim;
            o_match_valid    <= i_cand_valid;
            o_match_len      <= i_cand_len;
            o_offset         <= i_cand_offset;
        end
        if (i_summary_done) begin
            o_push_seq <= '{ll: i_summary_ll, ml: i_summary_ml, offset: i_summary_offset,
                            delim: i_summary_delim, eoj: i_summary_eoj,
                            overlap_len: i_summary_overlap_len};
        end
    end

    assign o_match_done = (state == ST_ISSUE) && !i_queue_full;
    assign o_push       = (state == ST_ACK);
    assign o_cand_ack   = (state == ST_ACK) || (state == ST_REQ_LOW);

endmodule

`default_nettype wire

/* source/seq_out_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module seq_out_queue import lz_pkg::*; (
    input  logic clk,
    input  logic i_rst_n,
    input  logic i_push,
    input  seq_t i_push_seq,
    input  logic i_seq_ack,
    output logic o_full,
    output logic o_seq_req,
    output seq_t o_seq
);

    seq_t                                 mem [SEQ_QUEUE_DEPTH];
    logic [$clog2(SEQ_QUEUE_DEPTH)-1:0]   wr_ptr;
    logic [$clog2(SEQ_QUEUE_DEPTH)-1:0]   rd_ptr;
    logic [$clog2(SEQ_QUEUE_DEPTH+1)-1:0] count;
    logic                                 pop;

    assign pop    = o_seq_req && i_seq_ack;  // ack high seen, entry taken
    assign o_full = (count == SEQ_QUEUE_DEPTH);
    assign o_seq  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_push) begin
            mem[wr_ptr] <= i_push_seq;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            count     <= '0;
            o_seq_req <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({i_push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase

            // next req waits for ack to fall
            if (pop) begin
                o_seq_req <= 1'b0;
            end else if (!o_seq_req && !i_seq_ack && (count != 0 || i_push)) begin
                o_seq_req <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* source/lazy_match_top.sv */
`timescale 1ns/1ps
`default_nettype none

module lazy_match_top import lz_pkg::*; (
    input  logic                                clk,
    input  logic                                i_rst_n,
    input  logic                                i_cand_req,
    input  logic [JOB_LEN_LOG2-1:0]             i_cand_match_head,
    input  logic                                i_cand_delim,
    input  logic [LAZY_LEN-1:0]                 i_cand_valid,
    input  logic [LAZY_LEN*MATCH_LEN_WIDTH-1:0] i_cand_len,
    input  logic [LAZY_LEN*SEQ_OFFSET_BITS-1:0] i_cand_offset,
    output logic                                o_cand_ack,
    output logic                                o_seq_req,
    output seq_t                                o_seq,
    input  logic                                i_seq_ack
);

    logic                                match_done;
    logic [JOB_LEN_LOG2-1:0]             seq_head_ptr;
    logic [JOB_LEN_LOG2-1:0]             match_head_ptr;
    logic                                delim;
    logic [LAZY_LEN-1:0]                 match_valid;
    logic [LAZY_LEN*MATCH_LEN_WIDTH-1:0] match_len;
    logic [LAZY_LEN*SEQ_OFFSET_BITS-1:0] offset;
    logic                                sum_done;
    logic [JOB_LEN_LOG2-1:0]             sum_head_ptr;
    logic [SEQ_LL_BITS-1:0]              sum_ll;
    logic [SEQ_ML_BITS-1:0]              sum_ml;
    logic [SEQ_OFFSET_BITS-1:0]          sum_offset;
    logic                                sum_delim;
    logic                                sum_eoj;
    logic [SEQ_ML_BITS-1:0]              sum_overlap_len;
    logic                                move_to_next_job;
    logic [MATCH_LEN_WIDTH-1:0]          move_forward;
    logic                                queue_full;
    logic                                push;
    seq_t                                push_seq;

    seq_scheduler u_sched (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_cand_req(i_cand_req), .i_cand_match_head(i_cand_match_head),
        .i_cand_delim(i_cand_delim), .i_cand_valid(i_cand_valid),
        .i_cand_len(i_cand_len), .i_cand_offset(i_cand_offset),
        .i_summary_done(sum_done), .i_summary_seq_head_ptr(sum_head_ptr),
        .i_summary_ll(sum_ll), .i_summary_ml(sum_ml), .i_summary_offset(sum_offset),
        .i_summary_delim(sum_delim), .i_summary_eoj(sum_eoj),
        .i_summary_overlap_len(sum_overlap_len), .i_move_to_next_job(move_to_next_job),
        .i_move_forward(move_forward), .i_queue_full(queue_full),
        .o_cand_ack(o_cand_ack), .o_match_done(match_done), .o_seq_head_ptr(seq_head_ptr),
        .o_match_head_ptr(match_head_ptr), .o_delim(delim), .o_match_valid(match_valid),
        .o_match_len(match_len), .o_offset(offset), .o_push(push), .o_push_seq(push_seq)
    );

    lazy_summary_pipeline u_pipe (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_match_done(match_done), .i_match_head_ptr(match_head_ptr),
        .i_seq_head_ptr(seq_head_ptr), .i_delim(delim), .i_match_valid(match_valid),
        .i_match_len(match_len), .i_offset(offset),
        .o_summary_done(sum_done), .o_seq_head_ptr(sum_head_ptr),
        .o_summary_ll(sum_ll), .o_summary_ml(sum_ml), .o_summary_offset(sum_offset),
        .o_summary_delim(sum_delim), .o_summary_eoj(sum_eoj),
        .o_summary_overlap_len(sum_overlap_len), .o_move_to_next_job(move_to_next_job),
        .o_move_forward(move_forward)
    );

    seq_out_queue u_queue (
        .clk(clk), .i_rst_n(i_rst_n),
        .i_push(push), .i_push_seq(push_seq), .i_seq_ack(i_seq_ack),
        .o_full(queue_full), .o_seq_req(o_seq_req), .o_seq(o_seq)
    );

endmodule

`default_nettype wire

/* dv/lazy_match_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module lazy_match_tb import lz_pkg::*; ();

    localparam int NUM_FIXED  = 12;
    localparam int NUM_ROWS   = 36;
    localparam int WAIT_LIMIT = 200;  // cycles per wait
    localparam int STALL      = 60;   // long ack hold

    logic                                clk = 1'b0;
    logic                                i_rst_n;
    logic                                i_cand_req;
    logic [JOB_LEN_LOG2-1:0]             i_cand_match_head;
    logic                                i_cand_delim;
    logic [LAZY_LEN-1:0]                 i_cand_valid;
    logic [LAZY_LEN*MATCH_LEN_WIDTH-1:0] i_cand_len;
    logic [LAZY_LEN*SEQ_OFFSET_BITS-1:0] i_cand_offset;
    logic                                o_cand_ack;
    logic                                o_seq_req;
    seq_t                                o_seq;
    logic                                i_seq_ack;

    int                         row_gap  [NUM_ROWS];  // match head minus seq head
    logic [JOB_LEN_LOG2-1:0]    row_mhead[NUM_ROWS];
    logic                       row_delim[NUM_ROWS];
    logic [LAZY_LEN-1:0]        row_valid[NUM_ROWS];
    logic [MATCH_LEN_WIDTH-1:0] row_len  [NUM_ROWS][LAZY_LEN];
    logic [SEQ_OFFSET_BITS-1:0] row_off  [NUM_ROWS][LAZY_LEN];
    seq_t                       row_exp  [NUM_ROWS];

    logic [31:0] lfsr_state = 32'h900d2e20;
    logic        prev_cand_req;
    logic        prev_cand_ack;
    logic        prev_seq_req;
    logic        prev_seq_ack;
    seq_t        prev_seq;
    int          full_cycles = 0;

    lazy_match_top u_dut (
        .clk               (clk),
        .i_rst_n           (i_rst_n),
        .i_cand_req        (i_cand_req),
        .i_cand_match_head (i_cand_match_head),
        .i_cand_delim      (i_cand_delim),
        .i_cand_valid      (i_cand_valid),
        .i_cand_len        (i_cand_len),
        .i_cand_offset     (i_cand_offset),
        .o_cand_ack        (o_cand_ack),
        .o_seq_req         (o_seq_req),
        .o_seq             (o_seq),
        .i_seq_ack         (i_seq_ack)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = {lfsr_state[30:0],
                          lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            v = {v[30:0], lfsr_state[0]};  // taps 32 22 2 1
        end
        return v;
    endfunction

    // expected record from the gain, tree and end-of-job rules
    function automatic seq_t model_record(input int r, input int head, output int next_head);
        int   ll[LAZY_LEN];
        int   gain[LAZY_LEN];
        int   cost;
        int   w_lo;
        int   w_hi;
        int   best;
        int   mf;
        int   overlap;
        seq_t rec;
        for (int i = 0; i < LAZY_LEN; i++) begin
            ll[i] = int'(row_mhead[r]) - head + i;
            cost  = 0;
            for (int b = 0; b < SEQ_OFFSET_BITS; b++) begin
                if (row_off[r][i][b]) begin
                    cost = b + 1;  // bit length of offset
                end
            end
            gain[i] = row_valid[r][i] ? 4 * int'(row_len[r][i]) + 4 * (LAZY_LEN - i) - cost
                                      : -(SEQ_OFFSET_BITS + 1);
        end
        w_lo    = (gain[0] > gain[1]) ? 0 : 1;  // equal gains pick the later one
        w_hi    = (gain[2] > gain[3]) ? 2 : 3;
        best    = (gain[w_lo] > gain[w_hi]) ? w_lo : w_hi;
        mf      = int'(row_len[r][best]) + ll[best];
        overlap = mf + head - JOB_LEN;
        rec = '{ll: SEQ_LL_BITS'(ll[best]), ml: SEQ_ML_BITS'(row_len[r][best]),
                offset: row_off[r][best], delim: row_delim[r], eoj: 1'b0, overlap_len: '0};
        if (overlap < 0) begin
            next_head = head + mf;
        end else if (row_delim[r]) begin
            rec.ll     = SEQ_LL_BITS'(JOB_LEN - head);  // trailing literals only
            rec.ml     = '0;
            rec.offset = '0;
            rec.eoj    = 1'b1;
            next_head  = 0;
        end else begin
            rec.eoj         = 1'b1;
            rec.overlap_len = SEQ_ML_BITS'(overlap);
            next_head       = overlap;
        end
        return rec;
    endfunction

    function automatic void set_row(input int r, input int gap, input logic delim,
                                    input logic [LAZY_LEN-1:0] valid,
                                    input int l0, l1, l2, l3, input int o0, o1, o2, o3);
        row_gap[r]   = gap;
        row_delim[r] = delim;
        row_valid[r] = valid;
        row_len[r]   = '{MATCH_LEN_WIDTH'(l0), MATCH_LEN_WIDTH'(l1),
                         MATCH_LEN_WIDTH'(l2), MATCH_LEN_WIDTH'(l3)};
        row_off[r]   = '{SEQ_OFFSET_BITS'(o0), SEQ_OFFSET_BITS'(o1),
                         SEQ_OFFSET_BITS'(o2), SEQ_OFFSET_BITS'(o3)};
    endfunction

    function automatic void build_table();
        int head;
        int next_head;
        head = 0;
        set_row(0,  2, 1'b0, 4'b1111,   3, 3, 10,  3,    16, 16,    16,    16);  // length
        set_row(1,  0, 1'b0, 4'b1111,   5, 5,  5,  5,     8,  8,     8,     8);  // lazy bonus
        set_row(2,  1, 1'b0, 4'b1111,   6, 6,  6,  6, 40000,  2, 40000, 40000);  // offset cost
        set_row(3,  3, 1'b0, 4'b1110,  50, 4,  4,  4,     1,  1,     1,     1);  // cand 0 invalid
        set_row(4,  0, 1'b0, 4'b0011,   4, 4,  9,  9,    16,  1,     1,     1);  // exact tie
        set_row(5,  5, 1'b0, 4'b1111,  20, 4,  4,  4,   100, 100,  100,   100);
        set_row(6, 10, 1'b0, 4'b1111,  30, 4,  4,  4,   300, 300,  300,   300);
        set_row(7,  2, 1'b0, 4'b1111,   3, 3,  3, 40,     4,  4,     4,     4);
        set_row(8,  7, 1'b0, 4'b1111,  60, 4,  4,  4,  2000, 2000, 2000, 2000);
        set_row(9,  3, 1'b0, 4'b1111,  50, 4,  4,  4,    64, 64,    64,    64);  // eoj, overlap
        set_row(10, 2, 1'b0, 4'b1111,  10, 4,  4,  4,     5,  5,     5,     5);
        set_row(11, 0, 1'b1, 4'b1111, 240, 4,  4,  4,     9,  9,     9,     9);  // eoj with delim
        for (int r = 0; r < NUM_ROWS; r++) begin
            if (r >= NUM_FIXED) begin
                row_gap[r]   = int'(rand_bits(2));
                row_delim[r] = 1'b0;
                row_valid[r] = LAZY_LEN'(rand_bits(LAZY_LEN));
                if (row_valid[r] == '0) begin
                    row_valid[r] = 4'b0001;  // at least one valid
                end
                for (int i = 0; i < LAZY_LEN; i++) begin
                    row_len[r][i] = MATCH_LEN_WIDTH'(rand_bits(5) + 1);
                    row_off[r][i] = SEQ_OFFSET_BITS'(rand_bits(SEQ_OFFSET_BITS));
                end
                if (head + row_gap[r] >= JOB_LEN) begin
                    row_gap[r] = 0;
                end
            end
            row_mhead[r] = JOB_LEN_LOG2'(head + row_gap[r]);
            row_exp[r]   = model_record(r, head, next_head);
            head         = next_head;
        end
    endfunction

    task automatic stop_with_failure();
        $display("Errors found");
        $fatal(1, "simulation stopped after a failed check");
    endtask

    task automatic compare_seq(input seq_t actual, input seq_t expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] t=%0d ns: %s got ll=%0d ml=%0d offset=%0d delim=%0b eoj=%0b ovl=%0d",
                     $time, what, actual.ll, actual.ml, actual.offset, actual.delim,
                     actual.eoj, actual.overlap_len);
            $display("[ERROR] t=%0d ns: %s expected ll=%0d ml=%0d offset=%0d delim=%0b eoj=%0b ovl=%0d",
                     $time, what, expected.ll, expected.ml, expected.offset, expected.delim,
                     expected.eoj, expected.overlap_len);
            stop_with_failure();
        end
    endtask

    task automatic compare_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] t=%0d ns: %s got %b, expected %b", $time, what, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic wait_level(input bit on_seq, input logic level);
        int   n;
        logic sample;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            sample = on_seq ? o_seq_req : o_cand_ack;
            if (n > WAIT_LIMIT && sample !== level) begin
                $display("Timed out after %0d cycles waiting for %s to become %0b",
                         WAIT_LIMIT, on_seq ? "o_seq_req" : "o_cand_ack", level);
                stop_with_failure();
            end
        end while (sample !== level);
    endtask

    task automatic send_sets();
        logic [LAZY_LEN*MATCH_LEN_WIDTH-1:0] len_bus;
        logic [LAZY_LEN*SEQ_OFFSET_BITS-1:0] off_bus;
        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int i = 0; i < LAZY_LEN; i++) begin
                len_bus[i*MATCH_LEN_WIDTH +: MATCH_LEN_WIDTH] = row_len[r][i];
                off_bus[i*SEQ_OFFSET_BITS +: SEQ_OFFSET_BITS] = row_off[r][i];
            end
            @(posedge clk);
            i_cand_match_head <= row_mhead[r];
            i_cand_delim      <= row_delim[r];
            i_cand_valid      <= row_valid[r];
            i_cand_len        <= len_bus;
            i_cand_offset     <= off_bus;
            i_cand_req        <= 1'b1;
            wait_level(1'b0, 1'b1);
            @(posedge clk);
            i_cand_req <= 1'b0;
            wait_level(1'b0, 1'b0);
        end
    endtask

    task automatic take_records();
        int delay;
        for (int k = 0; k < NUM_ROWS; k++) begin
            wait_level(1'b1, 1'b1);
            delay = int'(rand_bits(3));
            if (k == 8 || k == 20) begin
                delay = delay + STALL;  // lets the queue fill up
            end
            repeat (delay) @(negedge clk);
            compare_seq(o_seq, row_exp[k], $sformatf("record %0d", k));
            @(posedge clk);
            i_seq_ack <= 1'b1;
            wait_level(1'b1, 1'b0);
            @(posedge clk);
            i_seq_ack <= 1'b0;
        end
    endtask

    // four-phase levels on both ports
    always @(negedge clk) begin
        if (i_rst_n) begin
            if (o_cand_ack !== prev_cand_ack) begin
                compare_bit(prev_cand_req, o_cand_ack, "i_cand_req as o_cand_ack toggled");
            end
            if (o_seq_req !== prev_seq_req) begin
                compare_bit(prev_seq_ack, !o_seq_req, "i_seq_ack as o_seq_req toggled");
            end
            if (prev_seq_req && o_seq_req) begin
                compare_seq(o_seq, prev_seq, "o_seq held under o_seq_req");
            end
            if (u_dut.queue_full) begin
                full_cycles++;
            end
        end
        prev_cand_req = i_cand_req;
        prev_cand_ack = o_cand_ack;
        prev_seq_req  = o_seq_req;
        prev_seq_ack  = i_seq_ack;
        prev_seq      = o_seq;
    end

    initial begin
        i_rst_n           = 1'b0;
        i_cand_req        = 1'b0;
        i_cand_match_head = '0;
        i_cand_delim      = 1'b0;
        i_cand_valid      = '0;
        i_cand_len        = '0;
        i_cand_offset     = '0;
        i_seq_ack         = 1'b0;
        build_table();
        repeat (4) @(posedge clk);
        i_rst_n <= 1'b1;
        @(negedge clk);
        compare_bit(o_cand_ack, 1'b0, "o_cand_ack after reset");
        compare_bit(o_seq_req, 1'b0, "o_seq_req after reset");
        fork
            send_sets();
            take_records();
        join
        if (full_cycles == 0) begin
            $display("The output queue never filled, so back-pressure was not exercised");
            stop_with_failure();
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
source/lz_pkg.sv
source/priority_encoder.sv
source/lazy_summary_pipeline.sv
source/seq_scheduler.sv
source/seq_out_queue.sv
source/lazy_match_top.sv
dv/lazy_match_tb.sv

/* Makefile */
TOOL     := verilator
FLAGS    := --binary --timing -Wno-fatal -j 0
TOP      := lazy_match_tb
FILELIST := filelist.f
OUT_DIR  := obj_dir
LOG      := sim.log
PASS_MSG := No errors

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OUT_DIR) -f $(FILELIST)

run: compile
	-./$(OUT_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OUT_DIR) $(LOG)
